// ==== cpuPkg.sv ====
package cpuPkg;

  // instruction classes seen by execute
  typedef enum logic [2:0] {
    opAdd,
    opSub,
    opOr,
    opAnd,
    opAddi,
    opBru,
    opBcc,
    opNop
  } opCode;

  // conditional branch tests on register a, carried in rd[2:0]
  typedef enum logic [2:0] {
    condEq = 3'd0,
    condNe = 3'd1,
    condLt = 3'd2,
    condLe = 3'd3,
    condGt = 3'd4,
    condGe = 3'd5
  } bccCond;

  // operand source for the execute stage
  typedef enum logic {
    fwdReg,
    fwdExec
  } fwdSel;

  // raw opcode values, octal as in the instruction set
  localparam logic [5:0] opcAdd  = 6'o00;
  localparam logic [5:0] opcSub  = 6'o01;
  localparam logic [5:0] opcAddi = 6'o10;
  localparam logic [5:0] opcOr   = 6'o40;
  localparam logic [5:0] opcAnd  = 6'o41;
  localparam logic [5:0] opcBruR = 6'o46;
  localparam logic [5:0] opcBccR = 6'o47;
  localparam logic [5:0] opcBruI = 6'o56;
  localparam logic [5:0] opcBccI = 6'o57;

  // low half holds either rb plus spare bits or the immediate
  typedef struct packed {
    logic [4:0]  rb;
    logic [10:0] alt;
  } regOperand;

  typedef union packed {
    regOperand   r;
    logic [15:0] imm;
  } lowHalf;

  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rd;
    logic [4:0] ra;
    lowHalf     lo;
  } instFields;

  // decode to execute
  typedef struct packed {
    logic        valid;
    opCode       op;
    bccCond      cond;
    logic        delay;
    logic        absolute;
    logic [4:0]  rd;
    logic [31:0] regA;
    logic [31:0] regB;
    logic [31:0] imm;
    logic [29:0] pc;
  } decodeOut;

  // execute result, writeback and commit port
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [29:0] pc;
  } commitWr;

endpackage

// ==== fetchWb.sv ====
`timescale 1ns/1ps

module fetchWb #(
  parameter logic [29:0] resetPc = 30'd0
) (
  input  logic        gclk,
  input  logic        arstN,
  output logic        wbCyc,
  output logic        wbStb,
  output logic        wbWe,
  output logic [31:0] wbAdr,
  input  logic [31:0] wbDatI,
  input  logic        wbAck,
  input  logic [29:0] nextFetchAdr,
  output logic        stepEn,
  output logic [31:0] fetchWord,
  output logic [29:0] fetchPc
);

  typedef enum logic {
    stIdle,
    stBusy
  } fetchState;

  fetchState   state;
  logic [29:0] adrQ;

  // request lines follow the state directly
  assign wbCyc = (state == stBusy);
  assign wbStb = wbCyc;
  // instruction side never writes
  assign wbWe  = 1'b0;
  assign wbAdr = {adrQ, 2'b00};

  // one strobe per ack, moves the whole pipeline
  assign stepEn = wbCyc && wbAck;

  // idle for one cycle between requests
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
      adrQ  <= resetPc;
    end else begin
      case (state)
        stIdle: state <= stBusy;
        stBusy: begin
          if (wbAck) begin
            state <= stIdle;
            // branch unit already resolved the next address
            adrQ  <= nextFetchAdr;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // fetched word and its address
  always_ff @(posedge gclk) begin
    if (stepEn) begin
      fetchWord <= wbDatI;
      fetchPc   <= adrQ;
    end
  end

endmodule

// ==== instDecode.sv ====
`timescale 1ns/1ps

module instDecode (
  input  logic               gclk,
  input  logic               arstN,
  input  logic               stepEn,
  input  logic [31:0]        fetchWord,
  input  logic [29:0]        fetchPc,
  input  logic               decSkip,
  input  logic               exeSkip,
  input  cpuPkg::commitWr    execResult,
  output logic [4:0]         rfRdA,
  output logic [4:0]         rfRdB,
  input  logic [31:0]        rfDatA,
  input  logic [31:0]        rfDatB,
  output cpuPkg::decodeOut   decoded
);

  import cpuPkg::*;

  instFields   inst;
  opCode       opNext;
  logic        useImm;
  logic        fetchValid;
  logic [4:0]  rdNext;
  logic [31:0] immExt;
  logic [31:0] opA;
  logic [31:0] opB;
  fwdSel       selANext;
  fwdSel       selBNext;
  fwdSel       selA;
  fwdSel       selB;
  decodeOut    decQ;

  assign inst   = instFields'(fetchWord);
  assign rfRdA  = inst.ra;
  assign rfRdB  = inst.lo.r.rb;
  assign immExt = {{16{inst.lo.imm[15]}}, inst.lo.imm};
  // opcode bit 3 marks the immediate forms (10, 56, 57)
  assign useImm = inst.opc[3];

  always_comb begin
    case (inst.opc)
      opcAdd:           opNext = opAdd;
      opcSub:           opNext = opSub;
      opcOr:            opNext = opOr;
      opcAnd:           opNext = opAnd;
      opcAddi:          opNext = opAddi;
      opcBruR, opcBruI: opNext = opBru;
      opcBccR, opcBccI: opNext = opBcc;
      default:          opNext = opNop;
    endcase
  end

  // bcc uses rd as condition, nothing to write
  assign rdNext = (opNext == opBcc || opNext == opNop) ? 5'd0 : inst.rd;

  // result waiting for writeback, not yet in the register file
  assign opA = (execResult.valid && execResult.rd != 5'd0 && execResult.rd == inst.ra) ?
               execResult.data : rfDatA;
  assign opB = useImm ? immExt :
               (execResult.valid && execResult.rd != 5'd0 && execResult.rd == inst.lo.r.rb) ?
               execResult.data : rfDatB;

  // producer sits in execute right now, its result shows up one step later
  assign selANext = (decQ.valid && decQ.rd != 5'd0 && decQ.rd == inst.ra) ? fwdExec : fwdReg;
  assign selBNext = (!useImm && decQ.valid && decQ.rd != 5'd0 && decQ.rd == inst.lo.r.rb) ?
                    fwdExec : fwdReg;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      fetchValid <= 1'b0;
      decQ.valid <= 1'b0;
      selA       <= fwdReg;
      selB       <= fwdReg;
    end else if (stepEn) begin
      // first step after reset carries no fetched word yet
      fetchValid    <= 1'b1;
      decQ.valid    <= fetchValid && !decSkip && !exeSkip;
      decQ.op       <= opNext;
      decQ.cond     <= bccCond'(inst.rd[2:0]);
      decQ.delay    <= (opNext == opBru) ? inst.ra[4] : (opNext == opBcc) && inst.rd[4];
      decQ.absolute <= (opNext == opBru) && inst.ra[3];
      decQ.rd       <= rdNext;
      decQ.regA     <= opA;
      decQ.regB     <= opB;
      decQ.imm      <= immExt;
      decQ.pc       <= fetchPc;
      selA          <= selANext;
      selB          <= selBNext;
    end
  end

  // operand select applied at execute time
  always_comb begin
    decoded = decQ;
    if (selA == fwdExec) begin
      decoded.regA = execResult.data;
    end
    if (selB == fwdExec) begin
      decoded.regB = execResult.data;
    end
  end

endmodule

// ==== branchCtrl.sv ====
`timescale 1ns/1ps

module branchCtrl #(
  parameter logic [29:0] resetPc = 30'd0
) (
  input  logic             gclk,
  input  logic             arstN,
  input  logic             stepEn,
  input  cpuPkg::decodeOut decoded,
  output logic [29:0]      nextFetchAdr,
  output logic             decSkip,
  output logic             exeSkip
);

  import cpuPkg::*;

  logic        regZero;
  logic        regNeg;
  logic        careEq;
  logic        careLt;
  logic        invertAns;
  logic        condTrue;
  logic        taken;
  logic        skipQ;
  logic [31:0] target;
  logic [29:0] seqPtr;

  // register a tests, zero and sign only
  assign regZero = (decoded.regA == 32'd0);
  assign regNeg  = decoded.regA[31];

  // split each condition into an equal part, a less-than part
  // and a final invert
  always_comb begin
    careEq    = 1'b0;
    careLt    = 1'b0;
    invertAns = 1'b0;
    case (decoded.cond)
      condEq: careEq = 1'b1;
      condNe: begin
        careEq    = 1'b1;
        invertAns = 1'b1;
      end
      condLt: careLt = 1'b1;
      condLe: begin
        careEq = 1'b1;
        careLt = 1'b1;
      end
      // gt is le inverted
      condGt: begin
        careEq    = 1'b1;
        careLt    = 1'b1;
        invertAns = 1'b1;
      end
      // ge is lt inverted
      condGe: begin
        careLt    = 1'b1;
        invertAns = 1'b1;
      end
      default: begin
        // codes 6 and 7 never branch
        careEq = 1'b0;
      end
    endcase
  end

  assign condTrue = ((careEq && regZero) || (careLt && regNeg)) ^ invertAns;

  // bru always taken, bcc on its condition
  assign taken = decoded.valid &&
                 (decoded.op == opBru || (decoded.op == opBcc && condTrue));

  // absolute bru jumps to the operand, everything else is pc relative
  assign target = decoded.absolute ? decoded.regB : {decoded.pc, 2'b00} + decoded.regB;

  assign nextFetchAdr = taken ? target[31:2] : seqPtr;

  // b+4 is dropped unless it is the delay slot
  assign decSkip = taken && !decoded.delay;
  // b+8 reaches execute one step later and is always dropped
  assign exeSkip = skipQ;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      skipQ  <= 1'b0;
      // resetPc itself is the first request
      seqPtr <= resetPc + 30'd1;
    end else if (stepEn) begin
      skipQ  <= taken;
      seqPtr <= nextFetchAdr + 30'd1;
    end
  end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute #(
  parameter logic [29:0] resetPc = 30'd0
) (
  input  logic             gclk,
  input  logic             arstN,
  input  logic             stepEn,
  input  cpuPkg::decodeOut decoded,
  output logic [29:0]      nextFetchAdr,
  output logic             decSkip,
  output logic             exeSkip,
  output cpuPkg::commitWr  execResult
);

  import cpuPkg::*;

  logic [31:0] pcByte;
  logic [31:0] aluOut;

  assign pcByte = {decoded.pc, 2'b00};

  always_comb begin
    case (decoded.op)
      opAdd:   aluOut = decoded.regA + decoded.regB;
      // reverse subtract, rb minus ra
      opSub:   aluOut = decoded.regB - decoded.regA;
      opOr:    aluOut = decoded.regA | decoded.regB;
      opAnd:   aluOut = decoded.regA & decoded.regB;
      opAddi:  aluOut = decoded.regA + decoded.imm;
      // link value is the branch's own byte address
      opBru:   aluOut = pcByte;
      default: aluOut = 32'd0;
    endcase
  end

  branchCtrl #(
    .resetPc(resetPc)
  ) branchCtrl_i (
    .gclk        (gclk),
    .arstN       (arstN),
    .stepEn      (stepEn),
    .decoded     (decoded),
    .nextFetchAdr(nextFetchAdr),
    .decSkip     (decSkip),
    .exeSkip     (exeSkip)
  );

  // squashed entries keep flowing with valid low
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      execResult.valid <= 1'b0;
    end else if (stepEn) begin
      execResult.valid <= decoded.valid;
      execResult.rd    <= decoded.rd;
      // r0 targets commit zero data
      execResult.data  <= (decoded.rd == 5'd0) ? 32'd0 : aluOut;
      execResult.pc    <= decoded.pc;
    end
  end

endmodule

// ==== regResult.sv ====
`timescale 1ns/1ps

module regResult (
  input  logic            gclk,
  input  logic            arstN,
  input  logic            stepEn,
  input  cpuPkg::commitWr execResult,
  input  logic [4:0]      rfRdA,
  input  logic [4:0]      rfRdB,
  output logic [31:0]     rfDatA,
  output logic [31:0]     rfDatB,
  output cpuPkg::commitWr commit
);

  // 32 x 32, entry 0 never written
  logic [31:0] regFile [32];

  // asynchronous read, r0 reads zero
  assign rfDatA = (rfRdA == 5'd0) ? 32'd0 : regFile[rfRdA];
  assign rfDatB = (rfRdB == 5'd0) ? 32'd0 : regFile[rfRdB];

  // writeback
  always_ff @(posedge gclk) begin
    if (stepEn && execResult.valid && execResult.rd != 5'd0) begin
      regFile[execResult.rd] <= execResult.data;
    end
  end

  // commit valid lasts one cycle per step
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      commit.valid <= 1'b0;
    end else begin
      commit.valid <= stepEn && execResult.valid;
      if (stepEn) begin
        commit.rd   <= execResult.rd;
        commit.data <= execResult.data;
        commit.pc   <= execResult.pc;
      end
    end
  end

endmodule

// ==== miniCore.sv ====
`timescale 1ns/1ps

module miniCore #(
  parameter logic [29:0] resetPc = 30'd0
) (
  input  logic            gclk,
  input  logic            arstN,
  output logic            wbCyc,
  output logic            wbStb,
  output logic            wbWe,
  output logic [31:0]     wbAdr,
  input  logic [31:0]     wbDatI,
  input  logic            wbAck,
  output cpuPkg::commitWr commit
);

  import cpuPkg::*;

  // fetch side
  logic        stepEn;
  logic [31:0] fetchWord;
  logic [29:0] fetchPc;
  logic [29:0] nextFetchAdr;
  // squash lines from the branch unit
  logic        decSkip;
  logic        exeSkip;
  // register file read ports
  logic [4:0]  rfRdA;
  logic [4:0]  rfRdB;
  logic [31:0] rfDatA;
  logic [31:0] rfDatB;
  decodeOut    decoded;
  commitWr     execResult;

  fetchWb #(
    .resetPc(resetPc)
  ) fetchWb_i (
    .gclk        (gclk),
    .arstN       (arstN),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatI      (wbDatI),
    .wbAck       (wbAck),
    .nextFetchAdr(nextFetchAdr),
    .stepEn      (stepEn),
    .fetchWord   (fetchWord),
    .fetchPc     (fetchPc)
  );

  instDecode instDecode_i (
    .gclk      (gclk),
    .arstN     (arstN),
    .stepEn    (stepEn),
    .fetchWord (fetchWord),
    .fetchPc   (fetchPc),
    .decSkip   (decSkip),
    .exeSkip   (exeSkip),
    .execResult(execResult),
    .rfRdA     (rfRdA),
    .rfRdB     (rfRdB),
    .rfDatA    (rfDatA),
    .rfDatB    (rfDatB),
    .decoded   (decoded)
  );

  aluExecute #(
    .resetPc(resetPc)
  ) aluExecute_i (
    .gclk        (gclk),
    .arstN       (arstN),
    .stepEn      (stepEn),
    .decoded     (decoded),
    .nextFetchAdr(nextFetchAdr),
    .decSkip     (decSkip),
    .exeSkip     (exeSkip),
    .execResult  (execResult)
  );

  regResult regResult_i (
    .gclk      (gclk),
    .arstN     (arstN),
    .stepEn    (stepEn),
    .execResult(execResult),
    .rfRdA     (rfRdA),
    .rfRdB     (rfRdB),
    .rfDatA    (rfDatA),
    .rfDatB    (rfDatB),
    .commit    (commit)
  );

endmodule

// ==== core_checker.sv ====
`timescale 1ns/1ps

module coreChecker (
  input logic            gclk,
  input logic            arstN,
  input logic            wbCyc,
  input logic            wbStb,
  input logic [31:0]     wbAdr,
  input logic            wbAck,
  input cpuPkg::commitWr commit
);

  // strobe only inside a cycle
  stbInCyc: assert property (
    @(posedge gclk) disable iff (!arstN)
    wbStb |-> wbCyc
  ) else $error("wishbone stb high while cyc is low");

  // request held with a fixed address until the slave acks
  adrHeld: assert property (
    @(posedge gclk) disable iff (!arstN)
    (wbStb && !wbAck) |=> (wbStb && wbCyc && $stable(wbAdr))
  ) else $error("wishbone request dropped or address moved before ack");

  // bus quiet while reset is applied
  idleInReset: assert property (
    @(posedge gclk)
    !arstN |-> (!wbCyc && !wbStb)
  ) else $error("wishbone cyc or stb active during reset");

  // first cycle after release is still idle
  idleAfterReset: assert property (
    @(posedge gclk)
    $rose(arstN) |-> (!wbCyc && !wbStb)
  ) else $error("wishbone request started in the release cycle");

  // r0 never carries data out
  zeroRegData: assert property (
    @(posedge gclk) disable iff (!arstN)
    commit.valid |-> !(commit.rd == 5'd0 && commit.data != 32'd0)
  ) else $error("commit to r0 with nonzero data");

endmodule

// ==== coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

  import cpuPkg::*;

  localparam int progLen = 79;

  logic        gclk;
  logic        arstN;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [31:0] wbAdr;
  logic [31:0] wbDatI;
  logic        wbAck;
  commitWr     commit;

  logic [31:0] rom [128];
  logic [31:0] mregs [32];
  logic [29:0] expAdr [$];
  commitWr     expCommit [$];
  commitWr     expNow;
  logic [15:0] lfsr;
  logic [1:0]  waitCnt;
  logic        pending;
  logic        modelReady;
  int          fetchIdx;
  int          commitIdx;
  int          limitNs;

  miniCore #(
    .resetPc(30'd0)
  ) dut_i (
    .gclk  (gclk),
    .arstN (arstN),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbWe  (wbWe),
    .wbAdr (wbAdr),
    .wbDatI(wbDatI),
    .wbAck (wbAck),
    .commit(commit)
  );

  bind miniCore coreChecker checker_i (
    .gclk  (gclk),
    .arstN (arstN),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAdr (wbAdr),
    .wbAck (wbAck),
    .commit(commit)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic stepLfsr();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] encR(logic [5:0] opc, logic [4:0] rd, logic [4:0] ra,
                                       logic [4:0] rb);
    return {opc, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] encI(logic [5:0] opc, logic [4:0] rd, logic [4:0] ra,
                                       logic [15:0] imm);
    return {opc, rd, ra, imm};
  endfunction

  task automatic failValue(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic buildRom();
    int a;
    // unused opcode 77 decodes as nop with the address in the low bits
    for (int i = 0; i < 128; i++) begin
      rom[i] = {6'o77, 26'(i)};
    end
    rom[0] = encI(6'o10, 5'd1, 5'd0, 16'd5);
    rom[1] = encI(6'o10, 5'd2, 5'd0, 16'hfffd);
    // back to back with operands forwarded from execute
    rom[2] = encR(6'o00, 5'd3, 5'd1, 5'd2);
    rom[3] = encR(6'o01, 5'd4, 5'd3, 5'd1);
    rom[4] = encR(6'o40, 5'd5, 5'd4, 5'd2);
    rom[5] = encR(6'o41, 5'd6, 5'd5, 5'd1);
    // relative bru without delay slot to word 10
    rom[6] = encI(6'o56, 5'd0, 5'd0, 16'd16);
    rom[7] = encI(6'o10, 5'd20, 5'd20, 16'd55);
    rom[8] = encI(6'o10, 5'd21, 5'd21, 16'd66);
    rom[9] = encI(6'o10, 5'd22, 5'd22, 16'd77);
    // bcc eq on r0 with delay slot to word 13
    rom[10] = encI(6'o57, 5'b10000, 5'd0, 16'd12);
    rom[11] = encI(6'o10, 5'd8, 5'd0, 16'd7);
    rom[12] = encI(6'o10, 5'd8, 5'd8, 16'd100);
    // six conditions on zero, positive and negative register a
    for (int c = 0; c < 6; c++) begin
      for (int s = 0; s < 3; s++) begin
        a = 13 + 3 * (c * 3 + s);
        rom[a]     = encI(6'o57, 5'(c), 5'(s), 16'd12);
        rom[a + 1] = encI(6'o10, 5'd9, 5'd9, 16'd1);
        rom[a + 2] = encI(6'o10, 5'd10, 5'd10, 16'd1);
      end
    end
    // absolute bru with link to word 72
    rom[67] = encI(6'o10, 5'd11, 5'd0, 16'd288);
    rom[68] = encR(6'o46, 5'd12, 5'b01000, 5'd11);
    rom[69] = encI(6'o10, 5'd20, 5'd20, 16'd11);
    rom[70] = encI(6'o10, 5'd21, 5'd21, 16'd12);
    rom[71] = encI(6'o10, 5'd22, 5'd22, 16'd13);
    rom[72] = encR(6'o00, 5'd13, 5'd12, 5'd0);
    rom[73] = encI(6'o10, 5'd15, 5'd0, 16'd16);
    // relative register bru with link and delay slot to word 78
    rom[74] = encR(6'o46, 5'd14, 5'b10000, 5'd15);
    rom[75] = encR(6'o00, 5'd16, 5'd14, 5'd1);
    rom[76] = encI(6'o10, 5'd23, 5'd23, 16'd9);
    rom[77] = encI(6'o10, 5'd24, 5'd24, 16'd9);
    rom[78] = encR(6'o40, 5'd17, 5'd13, 5'd16);
  endtask

  // one instruction of the reference model
  task automatic execOne(input logic [29:0] pc, output logic taken, output logic delay,
                         output logic [29:0] tgt);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] byteTgt;
    logic [4:0]  dst;
    logic        cond;
    commitWr     c;
    w       = rom[pc[6:0]];
    a       = mregs[w[20:16]];
    b       = w[29] ? {{16{w[15]}}, w[15:0]} : mregs[w[15:11]];
    res     = 32'd0;
    dst     = 5'd0;
    taken   = 1'b0;
    delay   = 1'b0;
    byteTgt = 32'd0;
    cond    = 1'b0;
    case (w[31:26])
      6'o00, 6'o10: begin
        res = a + b;
        dst = w[25:21];
      end
      6'o01: begin
        res = b - a;
        dst = w[25:21];
      end
      6'o40: begin
        res = a | b;
        dst = w[25:21];
      end
      6'o41: begin
        res = a & b;
        dst = w[25:21];
      end
      6'o46, 6'o56: begin
        res     = {pc, 2'b00};
        dst     = w[25:21];
        taken   = 1'b1;
        delay   = w[20];
        byteTgt = w[19] ? b : {pc, 2'b00} + b;
      end
      6'o47, 6'o57: begin
        case (w[23:21])
          3'd0: cond = (a == 32'd0);
          3'd1: cond = (a != 32'd0);
          3'd2: cond = ($signed(a) < 0);
          3'd3: cond = ($signed(a) <= 0);
          3'd4: cond = ($signed(a) > 0);
          3'd5: cond = ($signed(a) >= 0);
          default: cond = 1'b0;
        endcase
        taken   = cond;
        delay   = w[25];
        byteTgt = {pc, 2'b00} + b;
      end
      default: res = 32'd0;
    endcase
    if (dst != 5'd0) begin
      mregs[dst] = res;
    end
    c.valid = 1'b1;
    c.rd    = dst;
    c.data  = (dst == 5'd0) ? 32'd0 : res;
    c.pc    = pc;
    expCommit.push_back(c);
    tgt = byteTgt[31:2];
  endtask

  // expected fetch and commit order
  task automatic runModel();
    logic [29:0] pc;
    logic        taken;
    logic        delay;
    logic [29:0] tgt;
    logic        t2;
    logic        d2;
    logic [29:0] tgt2;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = 32'd0;
    end
    pc = 30'd0;
    while (pc < 30'(progLen)) begin
      expAdr.push_back(pc);
      execOne(pc, taken, delay, tgt);
      if (taken) begin
        expAdr.push_back(pc + 30'd1);
        if (delay) begin
          execOne(pc + 30'd1, t2, d2, tgt2);
        end
        // b+8 is fetched but dropped
        expAdr.push_back(pc + 30'd2);
        pc = tgt;
      end else begin
        pc = pc + 30'd1;
      end
    end
  endtask

  initial begin
    gclk = 1'b0;
    forever #2 gclk = ~gclk;
  end

  // rom slave with 0 to 3 wait states per request
  initial begin
    forever begin
      @(posedge gclk);
      #1;
      if (wbAck) begin
        wbAck   = 1'b0;
        pending = 1'b0;
      end else if (arstN && wbCyc && wbStb) begin
        if (!pending) begin
          pending = 1'b1;
          waitCnt = {stepLfsr(), stepLfsr()};
        end
        if (waitCnt == 2'd0) begin
          wbAck  = 1'b1;
          wbDatI = (wbAdr[31:2] < 30'd128) ? rom[wbAdr[8:2]] : {6'o77, wbAdr[27:2]};
        end else begin
          waitCnt = waitCnt - 2'd1;
        end
      end
    end
  end

  // sampled mid cycle where bus and commit are settled
  always @(negedge gclk) begin
    if (arstN && wbCyc && wbStb && wbAck && fetchIdx < expAdr.size()) begin
      assert (wbAdr == {expAdr[fetchIdx], 2'b00})
        else failValue($sformatf("fetch %0d expected adr %h got %h", fetchIdx,
                                 {expAdr[fetchIdx], 2'b00}, wbAdr));
      // instruction fetches are reads only
      assert (wbWe == 1'b0)
        else failValue($sformatf("fetch %0d expected wbWe 0 got %b", fetchIdx, wbWe));
      fetchIdx++;
    end
    if (arstN && commit.valid && commitIdx < expCommit.size()) begin
      expNow = expCommit[commitIdx];
      assert (commit == expNow)
        else failValue($sformatf(
          "commit %0d expected pc %h rd %0d data %h got pc %h rd %0d data %h",
          commitIdx, expNow.pc, expNow.rd, expNow.data,
          commit.pc, commit.rd, commit.data));
      commitIdx++;
    end
  end

  // worst case five cycles per fetch plus margin
  initial begin
    wait (modelReady);
    #(limitNs);
    $display("timeout: the core stopped committing before the program ended");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    arstN      = 1'b0;
    wbAck      = 1'b0;
    wbDatI     = 32'd0;
    pending    = 1'b0;
    waitCnt    = 2'd0;
    lfsr       = 16'd31840;
    fetchIdx   = 0;
    commitIdx  = 0;
    modelReady = 1'b0;
    buildRom();
    runModel();
    limitNs    = expAdr.size() * 5 * 4 + 400;
    modelReady = 1'b1;
    repeat (5) @(posedge gclk);
    #1 arstN = 1'b1;
    wait (commitIdx == expCommit.size());
    repeat (4) @(posedge gclk);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
cpuPkg.sv
fetchWb.sv
instDecode.sv
branchCtrl.sv
aluExecute.sv
regResult.sv
miniCore.sv
core_checker.sv
coreTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = coreTb
FILELIST  = verilog.f
OBJDIR    = obj_dir

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJDIR)
